// ==== hw/ascii_pkg.sv ====
// ASCII characters and hex helpers
package ascii_pkg;

  typedef logic [7:0] char_t;                 // one transfer character

  // ********************************************************************
  // framing control characters
  // ********************************************************************
  localparam char_t c_soh = 8'h01;            // start of header
  localparam char_t c_sot = 8'h02;            // start of text
  localparam char_t c_eot = 8'h03;            // end of header
  localparam char_t c_eof = 8'h04;            // end of file
  localparam char_t c_cr  = 8'h0d;
  localparam char_t c_lf  = 8'h0a;

  // names sent in front of each dumped file, first character in the top byte
  localparam logic [39:0] out_name_dc = "Test1";
  localparam logic [39:0] out_name_ic = "Test2";

  // ********************************************************************
  // hex conversion
  // ********************************************************************

  // bit 4 is the valid flag, bits 3:0 the digit value
  function automatic logic [4:0] hex_to_nibble(input char_t c);
    logic [4:0] res;
    res = 5'b0_0000;                          // not a hex digit
    if (c >= "0" && c <= "9") begin
      res = {1'b1, c[3:0]};
    end else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f")) begin
      res = {1'b1, c[3:0] + 4'd9};            // low bits 1..6 map to 10..15
    end
    return res;
  endfunction

  // upper case digit for a nibble
  function automatic char_t nibble_to_hex(input logic [3:0] n);
    char_t ch;
    if (n <= 4'd9) begin
      ch = 8'h30 + {4'd0, n};                 // '0'..'9'
    end else begin
      ch = 8'h37 + {4'd0, n};                 // 'A'..'F'
    end
    return ch;
  endfunction

endpackage

// ==== hw/loader_pkg.sv ====
// loader types and sizes
package loader_pkg;

  // sizes of the two caches
  localparam int max_rows   = 64;             // upper bound for NUM_ROWS
  localparam int dc_nibbles = 8;              // hex digits per DC row
  localparam int ic_nibbles = 32;             // hex digits per IC row

  typedef logic [3:0]   nibble_t;             // one hex digit
  typedef logic [31:0]  dc_row_t;             // data cache row
  typedef logic [127:0] ic_row_t;             // instruction cache row, also the shared write bus

  // one bit more than 0..63 so NUM_ROWS itself fits as end marker
  typedef logic [6:0]   row_addr_t;

  typedef logic [4:0]   nib_idx_t;            // digit position inside a row

  // file id as carried in the frame, '0' or '1'
  typedef enum logic {
    file_dc,
    file_ic
  } file_id_t;

endpackage

// ==== hw/frame_parser.sv ====
// input frame parser
`timescale 1ns/1ns

module frame_parser (
  input  logic                 clk_sys,
  input  logic                 rst_clk,
  input  ascii_pkg::char_t     char_in,    // show-ahead data
  input  logic                 char_rdy,   // char_in valid
  input  logic                 dump_busy,  // input is held while dumping
  input  logic                 file_done,  // last row of the file seen
  output logic                 char_pop,
  output logic                 nib_valid,
  output loader_pkg::nibble_t  nib_value,
  output loader_pkg::file_id_t nib_file
);

  import ascii_pkg::*;
  import loader_pkg::*;

  typedef enum logic [1:0] {
    idle,                                   // look for SOH
    get_id,                                 // next char is the file id
    wait_sot,                               // skip until SOT
    data                                    // hex digits of the file
  } state_t;

  state_t     state;
  logic [4:0] hex_res;                      // {valid, value}

  // a character is taken whenever one is offered and no dump runs
  assign char_pop = char_rdy && !dump_busy;

  assign hex_res = hex_to_nibble(char_in);

  // ********************************************************************
  // framing FSM
  // ********************************************************************
  always_ff @(posedge clk_sys) begin
    if (rst_clk) begin
      state     <= idle;
      nib_valid <= 1'b0;
      nib_file  <= file_dc;
    end else begin
      nib_valid <= 1'b0;                    // single cycle strobe
      case (state)
        idle: begin
          if (char_pop && char_in == c_soh) state <= get_id;
        end
        get_id: begin
          if (char_pop) begin
            if (char_in == "0") begin
              nib_file <= file_dc;
              state    <= wait_sot;
            end else if (char_in == "1") begin
              nib_file <= file_ic;
              state    <= wait_sot;
            end else begin
              state    <= idle;             // unknown id, drop the frame
            end
          end
        end
        wait_sot: begin
          if (char_pop && char_in == c_sot) state <= data;
        end
        data: begin
          // file_done flags the last digit in flight, so the char taken now
          // already belongs to whatever follows the file
          if (file_done) begin
            state <= (char_pop && char_in == c_soh) ? get_id : idle;
          end else if (char_pop && hex_res[4]) begin
            nib_valid <= 1'b1;              // CR, LF and junk fall through
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // digit value rides along with nib_valid
  always_ff @(posedge clk_sys) begin
    if (char_pop) nib_value <= hex_res[3:0];
  end

  // digits only leave the parser while it sits inside a file body
  a_nib_only_in_data: assert property (
    @(posedge clk_sys) disable iff (rst_clk)
    nib_valid |-> state == data
  );

endmodule

// ==== hw/row_assembler.sv ====
// row packing and RAM write
`timescale 1ns/1ns

module row_assembler #(
  parameter int NUM_ROWS = loader_pkg::max_rows
) (
  input  logic                  clk_sys,
  input  logic                  rst_clk,
  input  logic                  nib_valid,
  input  loader_pkg::nibble_t   nib_value,
  input  loader_pkg::file_id_t  nib_file,
  input  logic                  dump_done,  // clears the loaded flags
  output logic                  dc_we,
  output logic                  ic_we,
  output loader_pkg::row_addr_t wr_addr,
  output loader_pkg::ic_row_t   row_data,   // DC takes the low 32 bits
  output logic                  file_done,
  output logic                  all_loaded
);

  import loader_pkg::*;

  localparam nib_idx_t  dc_last  = nib_idx_t'(dc_nibbles - 1);
  localparam nib_idx_t  ic_last  = nib_idx_t'(ic_nibbles - 1);
  localparam row_addr_t last_row = row_addr_t'(NUM_ROWS - 1);

  ic_row_t   row_q;                         // digits shift in at the bottom
  nib_idx_t  nib_cnt;                       // digits collected in this row
  row_addr_t row_cnt;                       // row being filled
  logic      dc_loaded;
  logic      ic_loaded;
  logic      row_end;                       // this digit closes a row
  logic      row_is_last;

  // row length depends on which file is coming in
  assign row_end     = nib_valid && (nib_cnt == ((nib_file == file_dc) ? dc_last : ic_last));
  assign row_is_last = (row_cnt == last_row);
  assign file_done   = row_end && row_is_last;  // parser may leave the body now

  assign row_data   = row_q;
  assign all_loaded = dc_loaded && ic_loaded;

  // ********************************************************************
  // row register and write address
  // ********************************************************************

  // shifting left leaves the first digit on top, both for 8 and 32 digits
  always_ff @(posedge clk_sys) begin
    if (nib_valid) row_q <= {row_q[$bits(ic_row_t) - 5:0], nib_value};
  end

  always_ff @(posedge clk_sys) begin
    if (row_end) wr_addr <= row_cnt;        // lines up with the write pulse
  end

  // ********************************************************************
  // counters, write pulses, loaded flags
  // ********************************************************************
  always_ff @(posedge clk_sys) begin
    if (rst_clk) begin
      dc_we     <= 1'b0;
      ic_we     <= 1'b0;
      nib_cnt   <= '0;
      row_cnt   <= '0;
      dc_loaded <= 1'b0;
      ic_loaded <= 1'b0;
    end else begin
      // one pulse per row, to the RAM of the current file
      dc_we <= row_end && (nib_file == file_dc);
      ic_we <= row_end && (nib_file == file_ic);

      if (nib_valid) begin
        nib_cnt <= row_end ? '0 : nib_cnt + 5'd1;
      end
      if (row_end) begin
        row_cnt <= row_is_last ? '0 : row_cnt + 7'd1;  // ready for the next file
      end

      if (dump_done) begin
        dc_loaded <= 1'b0;                  // files must be sent again
        ic_loaded <= 1'b0;
      end
      if (file_done) begin
        if (nib_file == file_dc) dc_loaded <= 1'b1;
        else ic_loaded <= 1'b1;
      end
    end
  end

  // the two RAMs share wr_addr and row_data
  a_one_write_port: assert property (
    @(posedge clk_sys) disable iff (rst_clk)
    !(dc_we && ic_we)
  );

endmodule

// ==== hw/dump_sequencer.sv ====
// cache dump sequencer
`timescale 1ns/1ns

module dump_sequencer #(
  parameter int NUM_ROWS = loader_pkg::max_rows
) (
  input  logic                  clk_sys,
  input  logic                  rst_clk,
  input  logic                  start_dump,
  input  logic                  all_loaded,
  input  logic                  out_full,   // output stream back-pressure
  input  loader_pkg::dc_row_t   dc_dout,    // one cycle after dc_rd_addr
  input  loader_pkg::ic_row_t   ic_dout,    // one cycle after ic_rd_addr
  output loader_pkg::row_addr_t dc_rd_addr,
  output loader_pkg::row_addr_t ic_rd_addr,
  output ascii_pkg::char_t      char_out,
  output logic                  char_we,
  output logic                  dump_busy,
  output logic                  dump_done
);

  import ascii_pkg::*;
  import loader_pkg::*;

  typedef enum logic [2:0] {
    idle,
    header,                                 // SOH, name, EOT, SOT
    fetch,                                  // covers the RAM read latency
    row_chars,                              // hex digits of one row
    line_end,                               // CR then LF
    eof_char,
    done                                    // one cycle, dump_done
  } state_t;

  localparam row_addr_t end_addr = row_addr_t'(NUM_ROWS);  // one past the last row
  localparam nib_idx_t  dc_last  = nib_idx_t'(dc_nibbles - 1);
  localparam nib_idx_t  ic_last  = nib_idx_t'(ic_nibbles - 1);

  state_t      state;
  file_id_t    cur_file;                    // file being sent
  logic [2:0]  hdr_idx;                     // position in the 8 char header
  nib_idx_t    nib_idx;                     // digit position in the row
  logic        lf_phase;                    // 0 = CR pending, 1 = LF pending
  row_addr_t   cur_addr;
  row_addr_t   next_addr;
  ic_row_t     cur_row;                     // RAM word, left aligned
  logic [39:0] cur_name;
  nibble_t     cur_nib;
  logic        nib_last;
  logic        emit;                        // a character is presented

  // ********************************************************************
  // selection by file
  // ********************************************************************
  assign cur_addr  = (cur_file == file_dc) ? dc_rd_addr : ic_rd_addr;
  assign next_addr = cur_addr + 7'd1;
  assign cur_name  = (cur_file == file_dc) ? out_name_dc : out_name_ic;
  assign nib_last  = (nib_idx == ((cur_file == file_dc) ? dc_last : ic_last));

  // DC row moved to the top so both files are read from the MSB down
  assign cur_row = (cur_file == file_dc) ?
                   {dc_dout, {($bits(ic_row_t) - $bits(dc_row_t)){1'b0}}} : ic_dout;
  assign cur_nib = cur_row[$bits(ic_row_t) - 1 - 4 * nib_idx -: 4];

  // ********************************************************************
  // output character
  // ********************************************************************
  always_comb begin
    emit     = 1'b1;
    char_out = c_eof;
    case (state)
      header: begin
        case (hdr_idx)
          3'd0:    char_out = c_soh;
          3'd6:    char_out = c_eot;
          3'd7:    char_out = c_sot;
          default: char_out = cur_name[8 * (6 - int'(hdr_idx)) - 1 -: 8];  // name, top byte first
        endcase
      end
      row_chars: char_out = nibble_to_hex(cur_nib);
      line_end:  char_out = lf_phase ? c_lf : c_cr;
      eof_char:  char_out = c_eof;
      default:   emit = 1'b0;               // idle, fetch, done
    endcase
  end

  assign char_we   = emit && !out_full;     // a write is also the advance
  assign dump_busy = (state != idle) && (state != done);
  assign dump_done = (state == done);

  // ********************************************************************
  // sequencing FSM
  // ********************************************************************
  always_ff @(posedge clk_sys) begin
    if (rst_clk) begin
      state      <= idle;
      cur_file   <= file_dc;
      hdr_idx    <= '0;
      nib_idx    <= '0;
      lf_phase   <= 1'b0;
      dc_rd_addr <= '0;
      ic_rd_addr <= '0;
    end else begin
      case (state)
        idle: begin
          if (start_dump && all_loaded) begin  // otherwise the start is dropped
            state      <= header;
            cur_file   <= file_dc;
            hdr_idx    <= '0;
            dc_rd_addr <= '0;
            ic_rd_addr <= '0;
          end
        end
        header: begin
          if (char_we) begin
            hdr_idx <= hdr_idx + 3'd1;      // wraps to 0 after SOT
            if (hdr_idx == 3'd7) state <= fetch;
          end
        end
        fetch: begin
          nib_idx <= '0;
          state   <= row_chars;             // RAM word valid from here on
        end
        row_chars: begin
          if (char_we) begin
            if (nib_last) begin
              nib_idx  <= '0;
              lf_phase <= 1'b0;
              state    <= line_end;
            end else begin
              nib_idx <= nib_idx + 5'd1;
            end
          end
        end
        line_end: begin
          if (char_we) begin
            if (!lf_phase) begin
              lf_phase <= 1'b1;
            end else begin
              lf_phase <= 1'b0;
              // address moves only after LF so the row holds during stalls
              if (cur_file == file_dc) dc_rd_addr <= next_addr;
              else ic_rd_addr <= next_addr;
              state <= (next_addr == end_addr) ? eof_char : fetch;
            end
          end
        end
        eof_char: begin
          if (char_we) begin
            if (cur_file == file_dc) begin
              cur_file <= file_ic;          // IC follows with its own header
              state    <= header;
            end else begin
              state <= done;
            end
          end
        end
        done:    state <= idle;
        default: state <= idle;
      endcase
    end
  end

  a_no_write_when_full: assert property (
    @(posedge clk_sys) disable iff (rst_clk)
    out_full |-> !char_we
  );

  // a stalled character stays put, which also needs the RAM to hold its word
  a_hold_on_stall: assert property (
    @(posedge clk_sys) disable iff (rst_clk)
    (emit && out_full) |=> (emit && $stable(char_out))
  );

endmodule

// ==== hw/file_loader_top.sv ====
// host file loader top level
`timescale 1ns/1ns

module file_loader_top #(
  parameter int NUM_ROWS = loader_pkg::max_rows  // rows per file, 64 at most
) (
  input  logic                  clk_sys,
  input  logic                  rst_clk,
  // character input, show-ahead
  input  ascii_pkg::char_t      char_in,
  input  logic                  char_rdy,
  output logic                  char_pop,
  // RAM write side
  output logic                  dc_we,
  output logic                  ic_we,
  output loader_pkg::row_addr_t wr_addr,
  output loader_pkg::ic_row_t   row_data,
  // RAM read side
  output loader_pkg::row_addr_t dc_rd_addr,
  output loader_pkg::row_addr_t ic_rd_addr,
  input  loader_pkg::dc_row_t   dc_dout,
  input  loader_pkg::ic_row_t   ic_dout,
  // dump control and character output
  input  logic                  start_dump,
  input  logic                  out_full,
  output ascii_pkg::char_t      char_out,
  output logic                  char_we,
  output logic                  dump_done,
  output logic                  all_loaded
);

  import loader_pkg::*;

  logic     dump_busy;                      // input side waits during a dump
  logic     file_done;
  logic     nib_valid;
  nibble_t  nib_value;
  file_id_t nib_file;

  frame_parser u_frame_parser (
    .clk_sys   (clk_sys),
    .rst_clk   (rst_clk),
    .char_in   (char_in),
    .char_rdy  (char_rdy),
    .dump_busy (dump_busy),
    .file_done (file_done),
    .char_pop  (char_pop),
    .nib_valid (nib_valid),
    .nib_value (nib_value),
    .nib_file  (nib_file)
  );

  row_assembler #(
    .NUM_ROWS (NUM_ROWS)
  ) u_row_assembler (
    .clk_sys    (clk_sys),
    .rst_clk    (rst_clk),
    .nib_valid  (nib_valid),
    .nib_value  (nib_value),
    .nib_file   (nib_file),
    .dump_done  (dump_done),
    .dc_we      (dc_we),
    .ic_we      (ic_we),
    .wr_addr    (wr_addr),
    .row_data   (row_data),
    .file_done  (file_done),
    .all_loaded (all_loaded)
  );

  dump_sequencer #(
    .NUM_ROWS (NUM_ROWS)
  ) u_dump_sequencer (
    .clk_sys    (clk_sys),
    .rst_clk    (rst_clk),
    .start_dump (start_dump),
    .all_loaded (all_loaded),
    .out_full   (out_full),
    .dc_dout    (dc_dout),
    .ic_dout    (ic_dout),
    .dc_rd_addr (dc_rd_addr),
    .ic_rd_addr (ic_rd_addr),
    .char_out   (char_out),
    .char_we    (char_we),
    .dump_busy  (dump_busy),
    .dump_done  (dump_done)
  );

endmodule

// ==== testbench/tb_bram_model.sv ====
// cache RAM models
`timescale 1ns/1ns

module tb_bram_model (
  input  logic                  clk_sys,
  input  logic                  dc_we,
  input  logic                  ic_we,
  input  loader_pkg::row_addr_t wr_addr,
  input  loader_pkg::ic_row_t   row_data,   // DC takes the low word
  input  loader_pkg::row_addr_t dc_rd_addr,
  input  loader_pkg::row_addr_t ic_rd_addr,
  output loader_pkg::dc_row_t   dc_dout,
  output loader_pkg::ic_row_t   ic_dout
);

  import loader_pkg::*;

  dc_row_t dc_mem [max_rows];
  ic_row_t ic_mem [max_rows];

  // distinct contents per row before any load
  initial begin
    logic [7:0] a;
    for (int i = 0; i < max_rows; i++) begin
      a = 8'(i);
      dc_mem[i] = {4{a}} ^ 32'h5a5a_5a5a;
      ic_mem[i] = {16{a}} ^ {4{32'hc3c3_3c3c}};
    end
  end

  // write port shared by both RAMs, read data one cycle after the address
  always @(posedge clk_sys) begin
    if (dc_we) dc_mem[wr_addr] <= row_data[31:0];
    if (ic_we) ic_mem[wr_addr] <= row_data;
    dc_dout <= dc_mem[dc_rd_addr];          // registered read
    ic_dout <= ic_mem[ic_rd_addr];
  end

endmodule

// ==== testbench/tb_file_loader_top.sv ====
// file loader testbench
`timescale 1ns/1ns

module tb_file_loader_top;

  import ascii_pkg::*;
  import loader_pkg::*;

  localparam int num_rows       = 4;
  localparam int timeout_cycles = 20000;    // both loads and the dump need about 1000

  logic      clk_sys = 1'b0;
  logic      rst_clk;
  char_t     char_in;
  logic      char_rdy;
  logic      char_pop;
  logic      start_dump;
  logic      out_full;
  logic      dc_we;
  logic      ic_we;
  row_addr_t wr_addr;
  ic_row_t   row_data;
  row_addr_t dc_rd_addr;
  row_addr_t ic_rd_addr;
  dc_row_t   dc_dout;
  ic_row_t   ic_dout;
  char_t     char_out;
  logic      char_we;
  logic      dump_done;
  logic      all_loaded;

  char_t   src_q[$];                        // show-ahead source contents
  char_t   out_q[$];                        // every character the DUT wrote
  dc_row_t dc_rows [num_rows];
  ic_row_t ic_rows [num_rows];
  int      dc_writes      = 0;
  int      ic_writes      = 0;
  int      done_pulses    = 0;
  int      cycle_count    = 0;
  int      mismatch_count = 0;
  int      fail_count     = 0;

  file_loader_top #(
    .NUM_ROWS (num_rows)
  ) u_file_loader_top (
    .clk_sys    (clk_sys),
    .rst_clk    (rst_clk),
    .char_in    (char_in),
    .char_rdy   (char_rdy),
    .char_pop   (char_pop),
    .dc_we      (dc_we),
    .ic_we      (ic_we),
    .wr_addr    (wr_addr),
    .row_data   (row_data),
    .dc_rd_addr (dc_rd_addr),
    .ic_rd_addr (ic_rd_addr),
    .dc_dout    (dc_dout),
    .ic_dout    (ic_dout),
    .start_dump (start_dump),
    .out_full   (out_full),
    .char_out   (char_out),
    .char_we    (char_we),
    .dump_done  (dump_done),
    .all_loaded (all_loaded)
  );

  tb_bram_model u_bram_model (
    .clk_sys    (clk_sys),
    .dc_we      (dc_we),
    .ic_we      (ic_we),
    .wr_addr    (wr_addr),
    .row_data   (row_data),
    .dc_rd_addr (dc_rd_addr),
    .ic_rd_addr (ic_rd_addr),
    .dc_dout    (dc_dout),
    .ic_dout    (ic_dout)
  );

  always #2 clk_sys = ~clk_sys;             // 4 ns period

  // **********************************************************************
  // source, monitors and watchdog
  // **********************************************************************

  // a pop takes the character shown in the cycle before this edge
  always @(posedge clk_sys) begin
    if (char_pop && src_q.size() > 0) void'(src_q.pop_front());
    if (src_q.size() > 0) begin
      char_rdy <= 1'b1;
      char_in  <= src_q[0];
    end else begin
      char_rdy <= 1'b0;
      char_in  <= '0;
    end
  end

  always @(posedge clk_sys) begin
    if (char_we) out_q.push_back(char_out);
    if (char_we && out_full) report_problem("character written while out_full was high");
    if (dc_we) dc_writes <= dc_writes + 1;
    if (ic_we) ic_writes <= ic_writes + 1;
    if (dump_done) done_pulses <= done_pulses + 1;
  end

  always @(posedge clk_sys) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // **********************************************************************
  // helpers
  // **********************************************************************
  task automatic report_mismatch(input string test_name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    mismatch_count++;
    $display("CHECK FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
  endtask

  task automatic report_problem(input string what);
    fail_count++;
    $display("ERROR: %s", what);
  endtask

  function automatic char_t hex_char(input nibble_t n, input bit lower);
    string digits;
    digits = lower ? "0123456789abcdef" : "0123456789ABCDEF";
    return digits[n];
  endfunction

  // top digit first, messy rows get lower case and junk in between
  task automatic push_row(input logic [127:0] row, input int digits, input bit messy);
    string junk;
    junk = " ,;xZ";
    for (int i = digits - 1; i >= 0; i--) begin
      src_q.push_back(hex_char(row[4 * i +: 4], messy && $urandom_range(1) == 1));
      if (messy && $urandom_range(3) == 0) src_q.push_back(junk[$urandom_range(4)]);
    end
    src_q.push_back(c_cr);
    src_q.push_back(c_lf);
  endtask

  // the last write pulse ends a file
  task automatic wait_for_load(input bit ic, input int target);
    int n;
    n = 0;
    while ((ic ? ic_writes : dc_writes) < target && n < 2000) begin
      @(posedge clk_sys);
      n++;
    end
    if (n >= 2000) report_problem("file load stopped before all rows were written");
    repeat (4) @(posedge clk_sys);         // trailing CR LF and flags settle
  endtask

  // **********************************************************************
  // tests
  // **********************************************************************
  task automatic test_reset();
    repeat (20) begin
      @(posedge clk_sys);
      if (char_pop !== 1'b0) report_mismatch("reset char_pop", 0, char_pop);
      if (dc_we !== 1'b0) report_mismatch("reset dc_we", 0, dc_we);
      if (ic_we !== 1'b0) report_mismatch("reset ic_we", 0, ic_we);
      if (char_we !== 1'b0) report_mismatch("reset char_we", 0, char_we);
      if (dump_done !== 1'b0) report_mismatch("reset dump_done", 0, dump_done);
      if (all_loaded !== 1'b0) report_mismatch("reset all_loaded", 0, all_loaded);
    end
  endtask

  task automatic test_dc_load();
    src_q.push_back(c_soh);
    src_q.push_back("0");
    src_q.push_back(c_sot);
    for (int r = 0; r < num_rows; r++) begin
      dc_rows[r] = $urandom;
      push_row(dc_rows[r], dc_nibbles, 1'b0);
    end
    wait_for_load(1'b0, num_rows);
    for (int r = 0; r < num_rows; r++) begin
      if (u_bram_model.dc_mem[r] !== dc_rows[r])
        report_mismatch($sformatf("dc load row %0d", r), dc_rows[r], u_bram_model.dc_mem[r]);
    end
    if (ic_writes != 0) report_problem("IC RAM written during the DC load");
    if (all_loaded !== 1'b0) report_mismatch("dc load all_loaded", 0, all_loaded);
  endtask

  task automatic test_ic_load();
    src_q.push_back(c_soh);
    src_q.push_back("1");
    src_q.push_back(" ");                   // skipped before SOT
    src_q.push_back(c_sot);
    for (int r = 0; r < num_rows; r++) begin
      ic_rows[r] = {$urandom, $urandom, $urandom, $urandom};
      push_row(ic_rows[r], ic_nibbles, 1'b1);
    end
    wait_for_load(1'b1, num_rows);
    for (int r = 0; r < num_rows; r++) begin
      if (u_bram_model.ic_mem[r] !== ic_rows[r])
        report_mismatch($sformatf("ic load row %0d", r), ic_rows[r], u_bram_model.ic_mem[r]);
    end
    if (dc_writes != num_rows) report_mismatch("ic load dc writes", num_rows, dc_writes);
    if (all_loaded !== 1'b1) report_mismatch("ic load all_loaded", 1, all_loaded);
  endtask

  task automatic test_dump();
    char_t   exp_q[$];
    string   name;
    ic_row_t row;
    int      digits;
    int      n;
    for (int f = 0; f < 2; f++) begin
      name = (f == 0) ? "Test1" : "Test2";
      digits = (f == 0) ? dc_nibbles : ic_nibbles;
      exp_q.push_back(c_soh);
      for (int k = 0; k < 5; k++) exp_q.push_back(name[k]);
      exp_q.push_back(c_eot);
      exp_q.push_back(c_sot);
      for (int r = 0; r < num_rows; r++) begin
        row = (f == 0) ? ic_row_t'(dc_rows[r]) : ic_rows[r];
        for (int i = digits - 1; i >= 0; i--) exp_q.push_back(hex_char(row[4 * i +: 4], 1'b0));
        exp_q.push_back(c_cr);
        exp_q.push_back(c_lf);
      end
      exp_q.push_back(c_eof);
    end
    out_q.delete();
    @(posedge clk_sys);
    start_dump <= 1'b1;
    n = 0;
    while (done_pulses == 0 && n < 4000) begin
      @(posedge clk_sys);
      start_dump <= 1'b0;
      out_full   <= ($urandom_range(3) == 0);  // stall about one cycle in four
      n++;
    end
    out_full <= 1'b0;
    if (n >= 4000) report_problem("dump_done never came after start_dump");
    repeat (5) @(posedge clk_sys);
    if (done_pulses != 1) report_mismatch("dump done pulses", 1, done_pulses);
    if (all_loaded !== 1'b0) report_mismatch("dump all_loaded", 0, all_loaded);
    if (out_q.size() != exp_q.size()) report_mismatch("dump length", exp_q.size(), out_q.size());
    for (int i = 0; i < exp_q.size() && i < out_q.size(); i++) begin
      if (out_q[i] !== exp_q[i]) report_mismatch($sformatf("dump char %0d", i), exp_q[i], out_q[i]);
    end
  endtask

  // files not sent again, so the start has to be dropped
  task automatic test_ignored_start();
    int n_chars;
    int n_done;
    n_chars = out_q.size();
    n_done  = done_pulses;
    @(posedge clk_sys);
    start_dump <= 1'b1;
    @(posedge clk_sys);
    start_dump <= 1'b0;
    repeat (200) @(posedge clk_sys);
    if (out_q.size() != n_chars) report_mismatch("ignored start chars", n_chars, out_q.size());
    if (done_pulses != n_done) report_mismatch("ignored start done", n_done, done_pulses);
  endtask

  initial begin
    void'($urandom(73));
    rst_clk    <= 1'b1;
    start_dump <= 1'b0;
    out_full   <= 1'b0;
    char_in    <= '0;
    char_rdy   <= 1'b0;
    repeat (3) @(posedge clk_sys);
    rst_clk <= 1'b0;
    test_reset();
    test_dc_load();
    test_ic_load();
    test_dump();
    test_ignored_start();
    $display("summary: %0d value mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0) $display("*** PASSED ***");
    else $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== flist.f ====
hw/ascii_pkg.sv
hw/loader_pkg.sv
hw/frame_parser.sv
hw/row_assembler.sv
hw/dump_sequencer.sv
hw/file_loader_top.sv
testbench/tb_bram_model.sv
testbench/tb_file_loader_top.sv
